// File: rtl/vdec_pkg.sv
/*
 * Vector decode package.
 * Opcodes, funct3/funct6 codes, decoded-op and control encodings,
 * and the instruction word union shared by the decode stage.
 */
package vdec_pkg;

  localparam int VLEN_REG_W = 5;

  typedef enum logic [6:0] {
    VECTOR   = 7'b1010111,
    LOAD_FP  = 7'b0000111,
    STORE_FP = 7'b0100111
  } opcode_e;

  typedef enum logic [2:0] {
    OPIVV = 3'b000,
    OPMVV = 3'b010,
    OPIVI = 3'b011,
    OPIVX = 3'b100,
    OPMVX = 3'b110,
    OPCFG = 3'b111
  } vfunct3_e;

  // one code per supported op
  typedef enum logic [5:0] {
    OP_VADD, OP_VSUB, OP_VRSUB,
    OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
    OP_VAND, OP_VOR, OP_VXOR,
    OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT,
    OP_VSLL, OP_VSRL, OP_VSRA,
    OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
    OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX,
    OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM,
    OP_VMULHU, OP_VMUL, OP_VMULHSU, OP_VMULH,
    BAD_OP
  } vop_e;

  typedef enum logic [1:0] {NOT_CFG, VSETVLI, VSETIVLI, VSETVL} cfgsel_e;

  typedef enum logic [1:0] {
    MOP_UNIT    = 2'b00,
    MOP_STRIDED = 2'b10
  } mop_e;

  typedef enum logic [2:0] {
    W8  = 3'b000,
    W16 = 3'b101,
    W32 = 3'b110,
    W64 = 3'b111
  } mem_width_e;

  typedef enum logic [2:0] {
    FU_NONE, FU_ARITH, FU_RED, FU_MUL, FU_DIV, FU_LOAD, FU_STORE
  } fu_e;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_RSUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_MM, ALU_COMP, ALU_SLL, ALU_SRL, ALU_SRA, ALU_NONE
  } valu_op_e;

  typedef enum logic [1:0] {SRC_V, SRC_X, SRC_I} src_type_e;

  // OPI funct6
  localparam logic [5:0] F6_VADD   = 6'b000000;
  localparam logic [5:0] F6_VSUB   = 6'b000010;
  localparam logic [5:0] F6_VRSUB  = 6'b000011;
  localparam logic [5:0] F6_VMINU  = 6'b000100;
  localparam logic [5:0] F6_VMIN   = 6'b000101;
  localparam logic [5:0] F6_VMAXU  = 6'b000110;
  localparam logic [5:0] F6_VMAX   = 6'b000111;
  localparam logic [5:0] F6_VAND   = 6'b001001;
  localparam logic [5:0] F6_VOR    = 6'b001010;
  localparam logic [5:0] F6_VXOR   = 6'b001011;
  localparam logic [5:0] F6_VMSEQ  = 6'b011000;
  localparam logic [5:0] F6_VMSNE  = 6'b011001;
  localparam logic [5:0] F6_VMSLTU = 6'b011010;
  localparam logic [5:0] F6_VMSLT  = 6'b011011;
  localparam logic [5:0] F6_VSLL   = 6'b100101;
  localparam logic [5:0] F6_VSRL   = 6'b101000;
  localparam logic [5:0] F6_VSRA   = 6'b101001;

  // OPM funct6
  localparam logic [5:0] F6_VREDSUM  = 6'b000000;
  localparam logic [5:0] F6_VREDAND  = 6'b000001;
  localparam logic [5:0] F6_VREDOR   = 6'b000010;
  localparam logic [5:0] F6_VREDXOR  = 6'b000011;
  localparam logic [5:0] F6_VREDMINU = 6'b000100;
  localparam logic [5:0] F6_VREDMIN  = 6'b000101;
  localparam logic [5:0] F6_VREDMAXU = 6'b000110;
  localparam logic [5:0] F6_VREDMAX  = 6'b000111;
  localparam logic [5:0] F6_VDIVU    = 6'b100000;
  localparam logic [5:0] F6_VDIV     = 6'b100001;
  localparam logic [5:0] F6_VREMU    = 6'b100010;
  localparam logic [5:0] F6_VREM     = 6'b100011;
  localparam logic [5:0] F6_VMULHU   = 6'b100100;
  localparam logic [5:0] F6_VMUL     = 6'b100101;
  localparam logic [5:0] F6_VMULHSU  = 6'b100110;
  localparam logic [5:0] F6_VMULH    = 6'b100111;

  // same 32 bits, seen as an arithmetic or a load/store word
  typedef union packed {
    struct packed {
      logic [5:0]            funct6;
      logic                  vm;
      logic [VLEN_REG_W-1:0] vs2;
      logic [VLEN_REG_W-1:0] vs1;
      logic [2:0]            funct3;
      logic [VLEN_REG_W-1:0] vd;
      logic [6:0]            opcode;
    } arith;
    struct packed {
      logic [2:0]            nf;
      logic                  mew;
      logic [1:0]            mop;
      logic                  vm;
      logic [4:0]            lumop;
      logic [VLEN_REG_W-1:0] rs1;
      logic [2:0]            width;
      logic [VLEN_REG_W-1:0] vd;
      logic [6:0]            opcode;
    } mem;
  } vinstr_u;

endpackage

// File: rtl/vec_arith_decode.sv
/*
 * Arithmetic decoder.
 * Maps OPI and OPM funct6/funct3 pairs onto a decoded op and flags illegal pairs.
 */
module vec_arith_decode (
  input  vdec_pkg::vinstr_u instr,
  output vdec_pkg::vop_e    op,
  output logic              arith_legal
);
  import vdec_pkg::*;

  logic is_vec;
  logic f3_vv;
  logic f3_vx;
  logic f3_vi;
  logic f3_mvv;
  logic f3_mvx;
  logic is_opi;
  logic is_opm;

  assign is_vec = (instr.arith.opcode == VECTOR);
  assign f3_vv  = (instr.arith.funct3 == OPIVV);
  assign f3_vx  = (instr.arith.funct3 == OPIVX);
  assign f3_vi  = (instr.arith.funct3 == OPIVI);
  assign f3_mvv = (instr.arith.funct3 == OPMVV);
  assign f3_mvx = (instr.arith.funct3 == OPMVX);

  assign is_opi = is_vec && (f3_vv || f3_vx || f3_vi);
  assign is_opm = is_vec && (f3_mvv || f3_mvx);

  always_comb begin
    op = BAD_OP;
    if (is_opi) begin
      case (instr.arith.funct6)
        F6_VADD:   if (f3_vv || f3_vx || f3_vi) op = OP_VADD;
        F6_VSUB:   if (f3_vv || f3_vx) op = OP_VSUB;
        F6_VRSUB:  if (f3_vx || f3_vi) op = OP_VRSUB;
        F6_VMINU:  if (f3_vv || f3_vx) op = OP_VMINU;
        F6_VMIN:   if (f3_vv || f3_vx) op = OP_VMIN;
        F6_VMAXU:  if (f3_vv || f3_vx) op = OP_VMAXU;
        F6_VMAX:   if (f3_vv || f3_vx) op = OP_VMAX;
        F6_VAND:   if (f3_vv || f3_vx || f3_vi) op = OP_VAND;
        F6_VOR:    if (f3_vv || f3_vx || f3_vi) op = OP_VOR;
        F6_VXOR:   if (f3_vv || f3_vx || f3_vi) op = OP_VXOR;
        F6_VMSEQ:  if (f3_vv || f3_vx || f3_vi) op = OP_VMSEQ;
        F6_VMSNE:  if (f3_vv || f3_vx || f3_vi) op = OP_VMSNE;
        // no immediate form for the less-than compares
        F6_VMSLTU: if (f3_vv || f3_vx) op = OP_VMSLTU;
        F6_VMSLT:  if (f3_vv || f3_vx) op = OP_VMSLT;
        F6_VSLL:   if (f3_vv || f3_vx || f3_vi) op = OP_VSLL;
        F6_VSRL:   if (f3_vv || f3_vx || f3_vi) op = OP_VSRL;
        F6_VSRA:   if (f3_vv || f3_vx || f3_vi) op = OP_VSRA;
        default:   op = BAD_OP;
      endcase
    end else if (is_opm) begin
      case (instr.arith.funct6)
        // reductions are vector-vector only
        F6_VREDSUM:  if (f3_mvv) op = OP_VREDSUM;
        F6_VREDAND:  if (f3_mvv) op = OP_VREDAND;
        F6_VREDOR:   if (f3_mvv) op = OP_VREDOR;
        F6_VREDXOR:  if (f3_mvv) op = OP_VREDXOR;
        F6_VREDMINU: if (f3_mvv) op = OP_VREDMINU;
        F6_VREDMIN:  if (f3_mvv) op = OP_VREDMIN;
        F6_VREDMAXU: if (f3_mvv) op = OP_VREDMAXU;
        F6_VREDMAX:  if (f3_mvv) op = OP_VREDMAX;
        F6_VDIVU:    op = OP_VDIVU;
        F6_VDIV:     op = OP_VDIV;
        F6_VREMU:    op = OP_VREMU;
        F6_VREM:     op = OP_VREM;
        F6_VMULHU:   op = OP_VMULHU;
        F6_VMUL:     op = OP_VMUL;
        F6_VMULHSU:  op = OP_VMULHSU;
        F6_VMULH:    op = OP_VMULH;
        default:     op = BAD_OP;
      endcase
    end
  end

  assign arith_legal = (op != BAD_OP);

endmodule

// File: rtl/vec_ctrl_combine.sv
/*
 * Control combine stage.
 * Merges arithmetic and memory/config decode into unit control and registers it.
 */
module vec_ctrl_combine (
  input  logic                            CLK,
  input  logic                            arst_n,
  input  logic                            instr_valid,
  input  vdec_pkg::vinstr_u               instr,
  input  vdec_pkg::vop_e                  op,
  input  logic                            arith_legal,
  input  logic                            is_load,
  input  logic                            is_store,
  input  logic                            stride,
  input  vdec_pkg::cfgsel_e               cfgsel,
  input  vdec_pkg::src_type_e             scalar_rs1,
  output logic                            ctrl_valid,
  output logic                            illegal_insn,
  output logic                            wen,
  output logic                            rd_scalar,
  output vdec_pkg::fu_e                   fu_type,
  output vdec_pkg::valu_op_e              aluop,
  output vdec_pkg::src_type_e             rs1_type,
  output vdec_pkg::src_type_e             rs2_type,
  output logic                            is_signed,
  output logic                            mul_high,
  output logic                            mem_load,
  output logic                            mem_store,
  output logic [vdec_pkg::VLEN_REG_W-1:0] vd
);
  import vdec_pkg::*;

  logic      cfg_insn;
  logic      vec_insn;
  logic      illegal_d;
  logic      wen_d;
  logic      signed_d;
  logic      mulh_d;
  fu_e       fu_d;
  valu_op_e  aluop_d;
  src_type_e rs1_d;

  assign cfg_insn  = (cfgsel != NOT_CFG);
  assign vec_insn  = (instr.arith.opcode == VECTOR);
  assign illegal_d = !(arith_legal || cfg_insn || is_load || is_store);
  assign wen_d     = is_load || arith_legal;

  always_comb begin
    fu_d = FU_NONE;
    if (is_load) begin
      fu_d = FU_LOAD;
    end else if (is_store) begin
      fu_d = FU_STORE;
    end else if (arith_legal) begin
      case (op)
        OP_VREDSUM, OP_VREDAND, OP_VREDOR, OP_VREDXOR,
        OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: fu_d = FU_RED;
        OP_VMULHU, OP_VMUL, OP_VMULHSU, OP_VMULH:         fu_d = FU_MUL;
        OP_VDIVU, OP_VDIV, OP_VREMU, OP_VREM:             fu_d = FU_DIV;
        default:                                          fu_d = FU_ARITH;
      endcase
    end
  end

  // reductions reuse the ALU code of their element op
  always_comb begin
    case (op)
      OP_VADD, OP_VREDSUM:    aluop_d = ALU_ADD;
      OP_VSUB:                aluop_d = ALU_SUB;
      OP_VRSUB:               aluop_d = ALU_RSUB;
      OP_VAND, OP_VREDAND:    aluop_d = ALU_AND;
      OP_VOR, OP_VREDOR:      aluop_d = ALU_OR;
      OP_VXOR, OP_VREDXOR:    aluop_d = ALU_XOR;
      OP_VMINU, OP_VMIN, OP_VMAXU, OP_VMAX,
      OP_VREDMINU, OP_VREDMIN, OP_VREDMAXU, OP_VREDMAX: aluop_d = ALU_MM;
      OP_VMSEQ, OP_VMSNE, OP_VMSLTU, OP_VMSLT:          aluop_d = ALU_COMP;
      OP_VSLL:                aluop_d = ALU_SLL;
      OP_VSRL:                aluop_d = ALU_SRL;
      OP_VSRA:                aluop_d = ALU_SRA;
      default:                aluop_d = ALU_NONE;
    endcase
  end

  always_comb begin
    if (vec_insn && ((instr.arith.funct3 == OPIVX) || (instr.arith.funct3 == OPMVX))) begin
      rs1_d = SRC_X;
    end else if (vec_insn && (instr.arith.funct3 == OPIVI)) begin
      rs1_d = SRC_I;
    end else begin
      rs1_d = scalar_rs1;
    end
  end

  always_comb begin
    case (op)
      OP_VMIN, OP_VMAX, OP_VMSLT, OP_VSRA, OP_VREDMIN, OP_VREDMAX,
      OP_VDIV, OP_VREM, OP_VMULH, OP_VMULHSU: signed_d = 1'b1;
      default:                                signed_d = 1'b0;
    endcase
  end

  assign mulh_d = (op == OP_VMULHU) || (op == OP_VMULHSU) || (op == OP_VMULH);

  // idle cycles present the inactive values
  always_ff @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      ctrl_valid   <= 1'b0;
      illegal_insn <= 1'b0;
      wen          <= 1'b0;
      rd_scalar    <= 1'b0;
      fu_type      <= FU_NONE;
      is_signed    <= 1'b0;
      mul_high     <= 1'b0;
      mem_load     <= 1'b0;
      mem_store    <= 1'b0;
    end else begin
      ctrl_valid   <= instr_valid;
      illegal_insn <= instr_valid && illegal_d;
      wen          <= instr_valid && wen_d;
      rd_scalar    <= instr_valid && cfg_insn;
      fu_type      <= instr_valid ? fu_d : FU_NONE;
      is_signed    <= instr_valid && signed_d;
      mul_high     <= instr_valid && mulh_d;
      mem_load     <= instr_valid && is_load;
      mem_store    <= instr_valid && is_store;
    end
  end

  // operand selects and destination
  always_ff @(posedge CLK) begin
    if (instr_valid) begin
      aluop    <= aluop_d;
      rs1_type <= rs1_d;
      rs2_type <= stride ? SRC_X : SRC_V;
      vd       <= instr.arith.vd;
    end
  end

endmodule

// File: rtl/vec_memcfg_decode.sv
/*
 * Load/store and configuration decoder.
 * Recognizes unit-stride and strided accesses and the vsetvl family.
 */
module vec_memcfg_decode #(
  parameter int ELEN = 32
) (
  input  vdec_pkg::vinstr_u   instr,
  output logic                is_load,
  output logic                is_store,
  output logic                stride,
  output vdec_pkg::cfgsel_e   cfgsel,
  output vdec_pkg::src_type_e scalar_rs1
);
  import vdec_pkg::*;

  logic width_ok;
  logic mop_ok;
  logic cfg_insn;

  // 64-bit elements only exist with ELEN 64
  assign width_ok = (instr.mem.width == W8) || (instr.mem.width == W16) ||
                    (instr.mem.width == W32) ||
                    ((ELEN == 64) && (instr.mem.width == W64));

  assign mop_ok = (instr.mem.mop == MOP_UNIT) || (instr.mem.mop == MOP_STRIDED);

  assign is_load  = (instr.mem.opcode == LOAD_FP) && width_ok && mop_ok;
  assign is_store = (instr.mem.opcode == STORE_FP) && width_ok && mop_ok;
  assign stride   = (is_load || is_store) && (instr.mem.mop == MOP_STRIDED);

  assign cfg_insn = (instr.arith.opcode == VECTOR) && (instr.arith.funct3 == OPCFG);

  // top bits of funct6 pick the config flavor
  always_comb begin
    cfgsel = NOT_CFG;
    if (cfg_insn) begin
      if (!instr.arith.funct6[5]) begin
        cfgsel = VSETVLI;
      end else if (instr.arith.funct6[4]) begin
        cfgsel = VSETIVLI;
      end else begin
        cfgsel = VSETVL;
      end
    end
  end

  always_comb begin
    if (is_load || is_store || (cfgsel == VSETVLI) || (cfgsel == VSETVL)) begin
      scalar_rs1 = SRC_X;
    end else if (cfgsel == VSETIVLI) begin
      scalar_rs1 = SRC_I;
    end else begin
      scalar_rs1 = SRC_V;
    end
  end

endmodule

// File: rtl/vector_control_unit.sv
/*
 * Vector decode stage top level.
 * Runs the arithmetic and memory/config decoders side by side, one-cycle registered control.
 */
module vector_control_unit #(
  parameter int ELEN = 32
) (
  input  logic                            CLK,
  input  logic                            arst_n,
  input  logic                            instr_valid,
  input  logic [31:0]                     instr,
  output logic                            ctrl_valid,
  output logic                            illegal_insn,
  output logic                            wen,
  output logic                            rd_scalar,
  output vdec_pkg::fu_e                   fu_type,
  output vdec_pkg::valu_op_e              aluop,
  output vdec_pkg::src_type_e             rs1_type,
  output vdec_pkg::src_type_e             rs2_type,
  output logic                            is_signed,
  output logic                            mul_high,
  output logic                            is_load,
  output logic                            is_store,
  output logic [vdec_pkg::VLEN_REG_W-1:0] vd
);
  import vdec_pkg::*;

  vinstr_u   instr_word;
  vop_e      op;
  logic      arith_legal;
  logic      dec_load;
  logic      dec_store;
  logic      stride;
  cfgsel_e   cfgsel;
  src_type_e scalar_rs1;

  assign instr_word = instr;

  vec_arith_decode u_arith (
    .instr       (instr_word),
    .op          (op),
    .arith_legal (arith_legal)
  );

  vec_memcfg_decode #(
    .ELEN (ELEN)
  ) u_memcfg (
    .instr      (instr_word),
    .is_load    (dec_load),
    .is_store   (dec_store),
    .stride     (stride),
    .cfgsel     (cfgsel),
    .scalar_rs1 (scalar_rs1)
  );

  vec_ctrl_combine u_combine (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr_word),
    .op           (op),
    .arith_legal  (arith_legal),
    .is_load      (dec_load),
    .is_store     (dec_store),
    .stride       (stride),
    .cfgsel       (cfgsel),
    .scalar_rs1   (scalar_rs1),
    .ctrl_valid   (ctrl_valid),
    .illegal_insn (illegal_insn),
    .wen          (wen),
    .rd_scalar    (rd_scalar),
    .fu_type      (fu_type),
    .aluop        (aluop),
    .rs1_type     (rs1_type),
    .rs2_type     (rs2_type),
    .is_signed    (is_signed),
    .mul_high     (mul_high),
    .mem_load     (is_load),
    .mem_store    (is_store),
    .vd           (vd)
  );

endmodule

// File: include/vcu_tb_model.svh
/*
 * Reference decode for the vector decode testbench.
 * Instruction builders and expected control for an ELEN 32 decode stage.
 */
`ifndef VCU_TB_MODEL_SVH
`define VCU_TB_MODEL_SVH

// random fields come from rnd, the opcode and selectors from the arguments
function automatic logic [31:0] arith_word(input logic [5:0] f6, input logic [2:0] f3,
                                           input logic [31:0] rnd);
  return {f6, rnd[25:15], f3, rnd[11:7], 7'b1010111};
endfunction

function automatic logic [31:0] mem_word(input logic store, input logic [1:0] mop,
                                         input logic [2:0] width, input logic [31:0] rnd);
  return {4'b0000, mop, rnd[25:15], width, rnd[11:7], store ? 7'b0100111 : 7'b0000111};
endfunction

function automatic logic [31:0] cfg_word(input logic [1:0] top, input logic [31:0] rnd);
  return {top, rnd[29:15], 3'b111, rnd[11:7], 7'b1010111};
endfunction

function automatic logic vec_f3(input logic [31:0] w, input logic [2:0] f3);
  return (w[6:0] == 7'b1010111) && (w[14:12] == f3);
endfunction

function automatic logic opi(input logic [31:0] w);
  return vec_f3(w, 3'b000) || vec_f3(w, 3'b011) || vec_f3(w, 3'b100);
endfunction

function automatic logic opm(input logic [31:0] w);
  return vec_f3(w, 3'b010) || vec_f3(w, 3'b110);
endfunction

// allowed forms, bit 0 vector, bit 1 scalar, bit 2 immediate
function automatic logic [2:0] opi_forms(input logic [5:0] f6);
  case (f6)
    6'b000000, 6'b001001, 6'b001010, 6'b001011, 6'b011000, 6'b011001,
    6'b100101, 6'b101000, 6'b101001: return 3'b111;
    6'b000010, 6'b000100, 6'b000101, 6'b000110, 6'b000111,
    6'b011010, 6'b011011: return 3'b011;
    6'b000011: return 3'b110;
    default: return 3'b000;
  endcase
endfunction

function automatic logic [2:0] opm_forms(input logic [5:0] f6);
  if (f6[5:3] == 3'b000) return 3'b001;
  if (f6[5:3] == 3'b100) return 3'b011;
  return 3'b000;
endfunction

function automatic logic arith_ok(input logic [31:0] w);
  logic [2:0] m;
  m = opm(w) ? opm_forms(w[31:26]) : opi_forms(w[31:26]);
  if (opi(w)) begin
    return (vec_f3(w, 3'b000) && m[0]) || (vec_f3(w, 3'b100) && m[1]) ||
           (vec_f3(w, 3'b011) && m[2]);
  end
  return opm(w) && ((vec_f3(w, 3'b010) && m[0]) || (vec_f3(w, 3'b110) && m[1]));
endfunction

function automatic logic mem_ok(input logic [31:0] w, input logic [6:0] opc);
  logic wid_ok;
  wid_ok = (w[14:12] == 3'b000) || (w[14:12] == 3'b101) || (w[14:12] == 3'b110);
  return (w[6:0] == opc) && wid_ok && ((w[27:26] == 2'b00) || (w[27:26] == 2'b10));
endfunction

function automatic logic ref_load(input logic [31:0] w);
  return mem_ok(w, 7'b0000111);
endfunction

function automatic logic ref_store(input logic [31:0] w);
  return mem_ok(w, 7'b0100111);
endfunction

function automatic logic ref_cfg(input logic [31:0] w);
  return vec_f3(w, 3'b111);
endfunction

function automatic logic ref_illegal(input logic [31:0] w);
  return !(arith_ok(w) || ref_cfg(w) || ref_load(w) || ref_store(w));
endfunction

function automatic logic ref_wen(input logic [31:0] w);
  return ref_load(w) || arith_ok(w);
endfunction

function automatic fu_e ref_fu(input logic [31:0] w);
  if (ref_load(w)) return FU_LOAD;
  if (ref_store(w)) return FU_STORE;
  if (!arith_ok(w)) return FU_NONE;
  if (!opm(w)) return FU_ARITH;
  if (!w[31]) return FU_RED;
  // 1001xx multiplies, 1000xx divides
  return w[28] ? FU_MUL : FU_DIV;
endfunction

function automatic valu_op_e ref_aluop(input logic [31:0] w);
  logic [5:0] f6;
  f6 = w[31:26];
  if (!arith_ok(w)) return ALU_NONE;
  if (opm(w)) begin
    if (f6[5]) return ALU_NONE;
    case (f6[2:0])
      3'd0: return ALU_ADD;
      3'd1: return ALU_AND;
      3'd2: return ALU_OR;
      3'd3: return ALU_XOR;
      default: return ALU_MM;
    endcase
  end
  case (f6)
    6'b000000: return ALU_ADD;
    6'b000010: return ALU_SUB;
    6'b000011: return ALU_RSUB;
    6'b001001: return ALU_AND;
    6'b001010: return ALU_OR;
    6'b001011: return ALU_XOR;
    6'b100101: return ALU_SLL;
    6'b101000: return ALU_SRL;
    6'b101001: return ALU_SRA;
    default: return (f6[5:2] == 4'b0001) ? ALU_MM : ALU_COMP;
  endcase
endfunction

function automatic src_type_e ref_rs1(input logic [31:0] w);
  if (vec_f3(w, 3'b100) || vec_f3(w, 3'b110)) return SRC_X;
  if (vec_f3(w, 3'b011)) return SRC_I;
  if (ref_cfg(w)) return (w[31:30] == 2'b11) ? SRC_I : SRC_X;
  if (ref_load(w) || ref_store(w)) return SRC_X;
  return SRC_V;
endfunction

function automatic src_type_e ref_rs2(input logic [31:0] w);
  return ((ref_load(w) || ref_store(w)) && (w[27:26] == 2'b10)) ? SRC_X : SRC_V;
endfunction

function automatic logic ref_signed(input logic [31:0] w);
  if (!arith_ok(w)) return 1'b0;
  if (opm(w)) begin
    case (w[31:26])
      6'b000101, 6'b000111, 6'b100001, 6'b100011, 6'b100110, 6'b100111: return 1'b1;
      default: return 1'b0;
    endcase
  end
  case (w[31:26])
    6'b000101, 6'b000111, 6'b011011, 6'b101001: return 1'b1;
    default: return 1'b0;
  endcase
endfunction

function automatic logic ref_mulh(input logic [31:0] w);
  return arith_ok(w) && opm(w) &&
         ((w[31:26] == 6'b100100) || (w[31:26] == 6'b100110) || (w[31:26] == 6'b100111));
endfunction

`endif

// File: tb/vcu_tb.sv
/*
 * Testbench for the vector decode stage.
 * Sends OPI, OPM, config and memory words and checks the registered control.
 */
module vcu_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import vdec_pkg::*;

  logic        CLK = 1'b0;
  logic        arst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic        ctrl_valid;
  logic        illegal_insn;
  logic        wen;
  logic        rd_scalar;
  fu_e         fu_type;
  valu_op_e    aluop;
  src_type_e   rs1_type;
  src_type_e   rs2_type;
  logic        is_signed;
  logic        mul_high;
  logic        is_load;
  logic        is_store;
  logic [4:0]  vd;
  logic [31:0] exp_word;
  logic        exp_valid;
  int          seed;
  int          test_errs;
  int          total_errs;
  int          tests_run;
  int          tests_failed;
  string       cur_test;

  `include "vcu_tb_model.svh"

  vector_control_unit #(
    .ELEN (32)
  ) DUT (
    .CLK          (CLK),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .ctrl_valid   (ctrl_valid),
    .illegal_insn (illegal_insn),
    .wen          (wen),
    .rd_scalar    (rd_scalar),
    .fu_type      (fu_type),
    .aluop        (aluop),
    .rs1_type     (rs1_type),
    .rs2_type     (rs2_type),
    .is_signed    (is_signed),
    .mul_high     (mul_high),
    .is_load      (is_load),
    .is_store     (is_store),
    .vd           (vd)
  );

  always #2 CLK = ~CLK;

  // word the DUT sampled at the last edge
  always @(posedge CLK or negedge arst_n) begin
    if (!arst_n) begin
      exp_valid <= 1'b0;
      exp_word  <= '0;
    end else begin
      exp_valid <= instr_valid;
      exp_word  <= instr;
    end
  end

  task automatic report_mismatch(input string field, input logic [31:0] expv,
                                 input logic [31:0] actv);
    $display("ERR %s %s expected %0h actual %0h word %h", cur_test, field, expv, actv,
             exp_word);
    test_errs++;
  endtask

  // outputs are stable at the falling edge
  always @(negedge CLK) begin
    assert (ctrl_valid === exp_valid) else report_mismatch("ctrl_valid", exp_valid, ctrl_valid);
    if (exp_valid !== 1'b1) begin
      assert (wen === 1'b0) else report_mismatch("wen", 0, wen);
      assert (is_load === 1'b0) else report_mismatch("is_load", 0, is_load);
      assert (is_store === 1'b0) else report_mismatch("is_store", 0, is_store);
      assert (illegal_insn === 1'b0) else report_mismatch("illegal_insn", 0, illegal_insn);
      assert (fu_type === FU_NONE) else report_mismatch("fu_type", FU_NONE, fu_type);
    end else begin
      assert (illegal_insn === ref_illegal(exp_word))
        else report_mismatch("illegal_insn", ref_illegal(exp_word), illegal_insn);
      assert (wen === ref_wen(exp_word)) else report_mismatch("wen", ref_wen(exp_word), wen);
      assert (rd_scalar === ref_cfg(exp_word))
        else report_mismatch("rd_scalar", ref_cfg(exp_word), rd_scalar);
      assert (fu_type === ref_fu(exp_word))
        else report_mismatch("fu_type", ref_fu(exp_word), fu_type);
      assert (aluop === ref_aluop(exp_word))
        else report_mismatch("aluop", ref_aluop(exp_word), aluop);
      assert (rs1_type === ref_rs1(exp_word))
        else report_mismatch("rs1_type", ref_rs1(exp_word), rs1_type);
      assert (rs2_type === ref_rs2(exp_word))
        else report_mismatch("rs2_type", ref_rs2(exp_word), rs2_type);
      assert (is_signed === ref_signed(exp_word))
        else report_mismatch("is_signed", ref_signed(exp_word), is_signed);
      assert (mul_high === ref_mulh(exp_word))
        else report_mismatch("mul_high", ref_mulh(exp_word), mul_high);
      assert (is_load === ref_load(exp_word))
        else report_mismatch("is_load", ref_load(exp_word), is_load);
      assert (is_store === ref_store(exp_word))
        else report_mismatch("is_store", ref_store(exp_word), is_store);
      assert (vd === exp_word[11:7]) else report_mismatch("vd", exp_word[11:7], vd);
    end
  end

  task automatic send_word(input logic [31:0] w);
    @(posedge CLK);
    instr       <= w;
    instr_valid <= 1'b1;
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      instr_valid <= 1'b0;
      instr       <= $random(seed);
    end
  endtask

  task automatic start_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  // drain the pipe, then report the test
  task automatic finish_test();
    int cycles;
    cycles = 0;
    idle_cycles(1);
    do begin
      @(negedge CLK);
      cycles++;
    end while ((ctrl_valid !== 1'b0) && (cycles < 8));
    if (ctrl_valid !== 1'b0) begin
      $display("%s: ctrl_valid stayed high after the last word", cur_test);
      test_errs++;
    end
    @(posedge CLK);
    $display("%-12s %0d errors", cur_test, test_errs);
    tests_run++;
    if (test_errs != 0) tests_failed++;
    total_errs += test_errs;
  endtask

  initial begin
    int          i;
    logic [31:0] r;
    logic [31:0] r2;
    logic [5:0]  f6;
    logic [2:0]  f3;
    seed         = 1043;
    arst_n       = 1'b0;
    instr_valid  = 1'b0;
    instr        = '0;
    total_errs   = 0;
    tests_run    = 0;
    tests_failed = 0;

    start_test("reset");
    repeat (16) @(posedge CLK);
    arst_n <= 1'b1;
    idle_cycles(4);
    finish_test();

    start_test("opi_decode");
    // vrsub has no vector-vector form
    send_word(arith_word(6'b000011, 3'b000, $random(seed)));
    for (i = 0; i < 200; i++) begin
      r  = $random(seed);
      f6 = r[31:26];
      while (r[0] && (opi_forms(f6) == 3'b000)) begin
        r2 = $random(seed);
        f6 = r2[5:0];
      end
      case ({$random(seed)} % 3)
        0: f3 = 3'b000;
        1: f3 = 3'b011;
        default: f3 = 3'b100;
      endcase
      send_word(arith_word(f6, f3, r));
    end
    finish_test();

    start_test("opm_decode");
    // reductions and mul/div in both MVV and MVX
    for (i = 0; i < 32; i++) begin
      f6 = {i[4], 2'b00, i[2:0]};
      f3 = i[3] ? 3'b110 : 3'b010;
      send_word(arith_word(f6, f3, $random(seed)));
    end
    finish_test();

    start_test("config");
    r = $random(seed);
    send_word(cfg_word({1'b0, r[0]}, $random(seed)));
    send_word(cfg_word(2'b11, $random(seed)));
    send_word(cfg_word(2'b10, $random(seed)));
    finish_test();

    start_test("memory");
    // width index 0..3 maps to 000, 101, 110, 111
    for (i = 0; i < 16; i++) begin
      send_word(mem_word(i[3], {i[2], 1'b0}, {i[1] | i[0], i[1], i[0]}, $random(seed)));
    end
    send_word(mem_word(1'b0, 2'b01, 3'b000, $random(seed)));
    r = $random(seed);
    send_word({r[31:7], 7'b0001011});
    finish_test();

    start_test("stream");
    for (i = 0; i < 50; i++) begin
      r = $random(seed);
      case (r[2:0])
        3'd0, 3'd1: send_word(arith_word(r[31:26], r[3] ? 3'b000 : 3'b100, $random(seed)));
        3'd2: send_word(arith_word({r[31], 2'b00, r[28:26]}, r[4] ? 3'b010 : 3'b110,
                                   $random(seed)));
        3'd3: send_word(cfg_word(r[31:30], $random(seed)));
        3'd4, 3'd5: send_word(mem_word(r[3], {r[4], 1'b0}, {r[5] | r[6], r[5], r[6]},
                                       $random(seed)));
        default: send_word($random(seed));
      endcase
      if (r[7] && r[8]) idle_cycles(1 + r[9]);
    end
    finish_test();

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
rtl/vdec_pkg.sv
rtl/vec_arith_decode.sv
rtl/vec_memcfg_decode.sv
rtl/vec_ctrl_combine.sv
rtl/vector_control_unit.sv
tb/vcu_tb.sv
